// File: tpuPkg.sv
package tpuPkg;

	localparam int addressWidth = 8;	// Program address bits
	localparam int countWidth = 6;	// Issue stamp bits
	localparam int stateWidth = 4;	// Status flags
	localparam int queueDepth = 4;	// Fetch queue entries

	typedef logic [addressWidth-1:0] addressT;
	typedef logic [countWidth-1:0] countT;	// Wraps at full width
	typedef logic [stateWidth-1:0] stateT;
	typedef logic [$clog2(stateWidth)-1:0] condT;	// Picks one status flag

	typedef enum logic [1:0] {
		opNop,	// Advance by one
		opCompare,	// Load status through a compare unit
		opJump,	// Absolute target
		opBranch	// Relative, conditional
	} opcodeT;

	// One 16-bit instruction word
	typedef struct packed {
		opcodeT opcode;
		logic unitSel;	// 0 for compare unit 1, 1 for unit 2
		condT cond;	// Status bit tested by a branch
		logic [10:0] operand;	// Jump target, branch offset or status value
	} instrT;

	// Issue stage to controller, 26 bits
	typedef struct packed {
		logic req;	// Instruction executed this cycle
		logic jump;
		logic branch;
		addressT src;	// Target or signed offset
		countT timingMy;	// Stamp of this instruction
		countT timingWb;	// Stamp of the last compare
		condT cond;
		logic selCondValid;	// Unit used by the last compare
	} execCtrlT;

	// Compare results, 6 bits
	typedef struct packed {
		logic condValid1;
		logic condValid2;
		stateT state;
	} condResultT;

endpackage

// File: programAddressControl.sv
`timescale 1ns/1ps

module programAddressControl (
	input logic clock,
	input logic reset,
	input logic hold,
	input tpuPkg::execCtrlT ctrl,
	input tpuPkg::condResultT result,
	output logic fetch,
	output tpuPkg::addressT address,
	output logic stallReq
);

	logic req;
	logic condValid;
	logic cmpIssue;
	logic ruleOk;
	logic ready;
	logic taken;
	logic update;
	tpuPkg::countT nextStamp;
	tpuPkg::addressT nextAddress;

	logic rReq;
	logic rCond;
	logic rPending;
	tpuPkg::countT rLastWb;
	tpuPkg::addressT rAddress;

	assign req = ctrl.req & ~hold;	// Nothing executes under hold

	// Valid pulse from the unit the last compare went through
	assign condValid = ctrl.selCondValid ? result.condValid2 : result.condValid1;

	// A new compare stamp shows up on the request that issues it
	assign cmpIssue = req & (ctrl.timingWb != rLastWb);

	// Branch must directly follow its compare
	assign nextStamp = ctrl.timingWb + 1'b1;
	assign ruleOk = ctrl.branch & (ctrl.timingMy == nextStamp);
	assign ready = ruleOk & rCond;	// Status holds the compare result
	assign taken = ready & result.state[ctrl.cond];

	// A branch that breaks the rule leaves the address alone
	// so the same word is fetched again
	assign update = req & (~ctrl.branch | ready);
	assign nextAddress = taken ? rAddress + ctrl.src : rAddress + 1'b1;

	// Hold back pops while a compare result is still on its way
	assign stallReq = (rReq | rPending) & ~rCond;

	assign fetch = rReq;
	assign address = rAddress;

	// Request retimed into the fetch pulse
	always_ff @(posedge clock) begin
		if (reset) begin
			rReq <= 1'b0;
		end else begin
			rReq <= req;
		end
	end

	// Fetch outstanding until its word is executed
	always_ff @(posedge clock) begin
		if (reset) begin
			rPending <= 1'b0;
		end else if (req) begin
			rPending <= 1'b0;
		end else if (rReq) begin
			rPending <= 1'b1;
		end
	end

	// Condition validated, dropped by each new compare
	always_ff @(posedge clock) begin
		if (reset) begin
			rCond <= 1'b1;	// No compare outstanding
		end else if (cmpIssue) begin
			rCond <= 1'b0;
		end else if (condValid) begin
			rCond <= 1'b1;
		end
	end

	// Tracks the last compare stamp seen, loaded during reset too
	always_ff @(posedge clock) begin
		rLastWb <= ctrl.timingWb;
	end

	// Program counter
	always_ff @(posedge clock) begin
		if (reset) begin
			rAddress <= '0;
		end else if (req & ctrl.jump) begin
			rAddress <= ctrl.src;	// Absolute target
		end else if (update) begin
			rAddress <= nextAddress;
		end
	end

endmodule

// File: fetchQueue.sv
`timescale 1ns/1ps

module fetchQueue (
	input logic clock,
	input logic reset,
	input logic writeEn,
	input tpuPkg::instrT writeData,
	input logic pop,
	output tpuPkg::instrT head,
	output logic notEmpty,
	output logic full
);

	tpuPkg::instrT mem [tpuPkg::queueDepth];
	logic [$clog2(tpuPkg::queueDepth)-1:0] rdPtr;
	logic [$clog2(tpuPkg::queueDepth)-1:0] wrPtr;
	logic [$clog2(tpuPkg::queueDepth+1)-1:0] fill;	// Occupancy
	logic doWrite;
	logic doRead;

	assign full = (fill == tpuPkg::queueDepth);
	assign notEmpty = (fill != '0);
	assign doWrite = writeEn & ~full;	// Dropped when full
	assign doRead = pop & notEmpty;	// Empty pop ignored
	assign head = mem[rdPtr];	// Show-ahead word

	// Storage
	always_ff @(posedge clock) begin
		if (doWrite) begin
			mem[wrPtr] <= writeData;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			fill <= '0;
		end else begin
			if (doWrite) begin
				wrPtr <= (wrPtr == tpuPkg::queueDepth - 1) ? '0 : wrPtr + 1'b1;
			end
			if (doRead) begin
				rdPtr <= (rdPtr == tpuPkg::queueDepth - 1) ? '0 : rdPtr + 1'b1;
			end
			case ({doWrite, doRead})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: fill <= fill;	// Both or neither
			endcase
		end
	end

endmodule

// File: issueStage.sv
`timescale 1ns/1ps

module issueStage (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic stallReq,
	input tpuPkg::instrT head,
	input logic notEmpty,
	output logic pop,
	output tpuPkg::execCtrlT ctrl,
	output tpuPkg::condResultT result
);

	logic isCompare;
	logic issueCompare;
	logic rBoot;
	tpuPkg::countT rCount;
	tpuPkg::countT rTimingWb;
	logic rSelCond;
	tpuPkg::stateT rState;

	// Compare unit 1, one stage
	logic u1Valid;
	tpuPkg::stateT u1Value;
	// Compare unit 2, two stages
	logic u2aValid;
	tpuPkg::stateT u2aValue;
	logic u2bValid;
	tpuPkg::stateT u2bValue;

	assign pop = notEmpty & ~hold & ~stallReq & ~rBoot;
	assign isCompare = (head.opcode == tpuPkg::opCompare);
	assign issueCompare = pop & isCompare;

	// Decode toward the controller
	always_comb begin
		ctrl.req = pop | (rBoot & ~hold);
		ctrl.jump = rBoot | (head.opcode == tpuPkg::opJump);	// Bootstrap jumps to 0
		ctrl.branch = ~rBoot & (head.opcode == tpuPkg::opBranch);
		ctrl.src = rBoot ? '0 : head.operand[tpuPkg::addressWidth-1:0];
		ctrl.timingMy = rCount;
		ctrl.timingWb = issueCompare ? rCount : rTimingWb;	// Own stamp on a compare
		ctrl.cond = head.cond;
		ctrl.selCondValid = rSelCond;
	end

	// Status visible in the cycle of the valid pulse
	assign result.condValid1 = u1Valid;
	assign result.condValid2 = u2bValid;
	assign result.state = u1Valid ? u1Value : (u2bValid ? u2bValue : rState);

	// One bootstrap request after reset
	always_ff @(posedge clock) begin
		if (reset) begin
			rBoot <= 1'b1;
		end else if (~hold) begin
			rBoot <= 1'b0;
		end
	end

	// Issue stamps and last compare info
	always_ff @(posedge clock) begin
		if (reset) begin
			rCount <= '0;
			rTimingWb <= {{(tpuPkg::countWidth-1){1'b1}}, 1'b0};	// Matches no early branch
			rSelCond <= 1'b0;
		end else begin
			if (pop) begin
				rCount <= rCount + 1'b1;	// Wraps
			end
			if (issueCompare) begin
				rTimingWb <= rCount;
				rSelCond <= head.unitSel;
			end
		end
	end

	// Compare pipelines, valid bits only
	always_ff @(posedge clock) begin
		if (reset) begin
			u1Valid <= 1'b0;
			u2aValid <= 1'b0;
			u2bValid <= 1'b0;
		end else begin
			u1Valid <= issueCompare & ~head.unitSel;
			u2aValid <= issueCompare & head.unitSel;
			u2bValid <= u2aValid;
		end
	end

	always_ff @(posedge clock) begin
		u1Value <= head.operand[tpuPkg::stateWidth-1:0];
		u2aValue <= head.operand[tpuPkg::stateWidth-1:0];
		u2bValue <= u2aValue;
	end

	// Status register
	always_ff @(posedge clock) begin
		if (reset) begin
			rState <= '0;
		end else if (u1Valid) begin
			rState <= u1Value;
		end else if (u2bValid) begin
			rState <= u2bValue;
		end
	end

endmodule

// File: sequencerTop.sv
`timescale 1ns/1ps

module sequencerTop (
	input logic clock,
	input logic reset,
	input logic hold,
	input tpuPkg::instrT instr,
	input logic instrValid,
	output logic fetch,
	output tpuPkg::addressT address
);

	tpuPkg::execCtrlT ctrl;	// Issue stage to controller
	tpuPkg::condResultT result;	// Compare results
	logic stallReq;
	tpuPkg::instrT head;	// Queue head, show-ahead
	logic notEmpty;
	logic pop;
	logic full;	// Observed by the bound properties

	// Program counter and fetch requests
	programAddressControl programAddressControl_i (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.ctrl(ctrl),
		.result(result),
		.fetch(fetch),
		.address(address),
		.stallReq(stallReq)
	);

	// Returned words wait here
	fetchQueue fetchQueue_i (
		.clock(clock),
		.reset(reset),
		.writeEn(instrValid),
		.writeData(instr),
		.pop(pop),
		.head(head),
		.notEmpty(notEmpty),
		.full(full)
	);

	// Decode, stamps, compare units
	issueStage issueStage_i (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.stallReq(stallReq),
		.head(head),
		.notEmpty(notEmpty),
		.pop(pop),
		.ctrl(ctrl),
		.result(result)
	);

endmodule

// File: sequencerTop_properties.sv
`timescale 1ns/1ps

module sequencerTopProperties (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic fetch,
	input logic full,
	input logic stallReq,
	input tpuPkg::execCtrlT ctrl
);

	// Fetch queue never has to drop a returned word
	noFetchWhenFull: assert property (@(posedge clock) disable iff (reset)
		$rose(fetch) |-> !full)
		else $error("fetch raised while the fetch queue is full");

	// Controller leaves reset without a stall
	noStallAfterReset: assert property (@(posedge clock) reset |=> !stallReq)
		else $error("stallReq high after reset");

	noReqUnderHold: assert property (@(posedge clock) hold |-> !ctrl.req)	// Nothing executes
		else $error("req high while hold is high");

endmodule

bind sequencerTop sequencerTopProperties sequencerTopProperties_i (
	.clock(clock),
	.reset(reset),
	.hold(hold),
	.fetch(fetch),
	.full(full),
	.stallReq(stallReq),
	.ctrl(ctrl)
);

// File: sequencerTb.sv
`timescale 1ns/1ps

module sequencerTb;

	localparam int imageWords = 64;	// Program image size
	localparam int traceMax = 40;	// Longest fetch trace
	localparam int cyclesPerEntry = 30;	// Budget per traced fetch
	localparam int resetCycles = 10;
	localparam int passCount = 2;	// Without and with hold
	localparam int timeoutCycles = passCount * (resetCycles + 1 + traceMax * cyclesPerEntry);

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic hold = 1'b0;
	tpuPkg::instrT instr = '0;
	logic instrValid = 1'b0;
	logic fetch;
	tpuPkg::addressT address;

	logic [15:0] testData [imageWords + traceMax];	// Image, then trace
	int traceLen;
	int traceIdx = 0;	// Next trace entry to compare
	logic checking = 1'b0;
	logic holdEnable = 1'b0;
	logic [31:0] lfsr = 32'h77;
	logic seenFetch = 1'b0;	// Fetch as sampled mid-cycle
	tpuPkg::addressT seenAddress = '0;
	tpuPkg::addressT expected;
	string testName = "startup";

	sequencerTop sequencerTop_i (
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.instr(instr),
		.instrValid(instrValid),
		.fetch(fetch),
		.address(address)
	);

	always #5 clock = ~clock;	// 10 ns period

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	// Reset, then wait until the whole trace has been fetched
	task automatic runPass(input string name, input logic withHold);
		@(posedge clock);
		testName = name;
		checking <= 1'b0;	// Trace index rewinds at the next negedge
		holdEnable <= withHold;
		reset <= 1'b1;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;
		checking <= 1'b1;
		while (traceIdx < traceLen) begin
			@(posedge clock);
		end
	endtask

	// Instruction memory answers the fetch seen in the cycle before
	always @(posedge clock) begin
		if (reset) begin
			instrValid <= 1'b0;
		end else begin
			instrValid <= seenFetch;	// One-cycle pulse per fetch
			instr <= testData[seenAddress[5:0]];
		end
		if (holdEnable) begin
			lfsr = nextLfsr(lfsr);	// One step per hold bit
			hold <= lfsr[0];
		end else begin
			hold <= 1'b0;
		end
	end

	// Outputs sampled away from the rising edge
	always @(negedge clock) begin
		seenFetch = fetch;
		seenAddress = address;
		if (!checking) begin
			traceIdx = 0;
		end else if (fetch && traceIdx < traceLen) begin
			expected = testData[imageWords + traceIdx][7:0];
			traceIdx = traceIdx + 1;
			assert (address == expected) else stopRun($sformatf(
				"error: %s trace entry %0d expected %02h actual %02h",
				testName, traceIdx - 1, expected, address));
		end
	end

	initial begin
		for (int i = 0; i < imageWords + traceMax; i++) begin
			testData[i] = {8'h80, i[7:0]};	// Jump to self
		end
		$readmemh("testdata.txt", testData);
		traceLen = 0;
		while (traceLen < traceMax && testData[imageWords + traceLen] != 16'h00ff) begin
			traceLen++;
		end
		if (traceLen == 0) begin
			stopRun("testdata.txt holds no fetch trace");
		end else begin
			runPass("plain run", 1'b0);	// Jumps, branches, both compare units
			runPass("random hold", 1'b1);	// Same trace, other timing
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

	// Watchdog
	initial begin
		repeat (timeoutCycles) @(posedge clock);
		stopRun($sformatf("timeout after %0d cycles, fetch trace not completed",
			timeoutCycles));
	end

endmodule

// File: testdata.txt
// Program image, one 16-bit instruction word per column, from address 00
// Expected fetch addresses from 40 on, one per column, FF marks the end
@00
0000 0000 0000 8010
@08
4002 C020 0000 800B
@10
0000 4004 D008
@1A
6001 D8FB 6008 D8EB
@40
00 01 02 03 10 11 12 1A
1B 1C 1D 08 09 0A 0B 0B
0B FF

// File: tb.f
tpuPkg.sv
programAddressControl.sv
fetchQueue.sv
issueStage.sv
sequencerTop.sv
sequencerTop_properties.sv
sequencerTb.sv

// File: run.sh
#!/bin/sh
# Build and run the sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module sequencerTb -f tb.f -o sequencerSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sequencerSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
exit 0
